/* video_timing_pkg.sv */
`default_nettype none

package video_timing_pkg;

	typedef logic [10:0] count_t;   // Pixel or line count or threshold
	typedef logic [3:0]  sw_code_t; // Raw switch code

	////////////////////////////////////////////////////////////////////////////
	// Switch codes per display format
	////////////////////////////////////////////////////////////////////////////
	localparam sw_code_t SW_VGA      = 4'b0000;
	localparam sw_code_t SW_SVGA     = 4'b0001;
	localparam sw_code_t SW_HDTV720P = 4'b0010; // Also any unlisted code
	localparam sw_code_t SW_XGA      = 4'b0011;
	localparam sw_code_t SW_SXGA     = 4'b1000;
	localparam sw_code_t SW_CAMERA   = 4'b1001;

	localparam int SW_SYNC_STAGES = 2; // Switch synchronizer depth
	localparam int OUT_LATENCY    = 2; // Register stages in the output aligner

	////////////////////////////////////////////////////////////////////////////
	// Per-format timing in pixels and lines
	////////////////////////////////////////////////////////////////////////////
	// 640x480@60
	localparam count_t HPIXELS_VGA      = 11'd640;
	localparam count_t HFNPRCH_VGA      = 11'd16;
	localparam count_t HSYNCPW_VGA      = 11'd96;
	localparam count_t HBKPRCH_VGA      = 11'd48;
	localparam count_t VLINES_VGA       = 11'd480;
	localparam count_t VFNPRCH_VGA      = 11'd11;
	localparam count_t VSYNCPW_VGA      = 11'd2;
	localparam count_t VBKPRCH_VGA      = 11'd31;
	localparam logic   NEG_POLARITY_VGA = 1'b1; // Syncs idle high

	// 800x600@60
	localparam count_t HPIXELS_SVGA      = 11'd800;
	localparam count_t HFNPRCH_SVGA      = 11'd40;
	localparam count_t HSYNCPW_SVGA      = 11'd128;
	localparam count_t HBKPRCH_SVGA      = 11'd88;
	localparam count_t VLINES_SVGA       = 11'd600;
	localparam count_t VFNPRCH_SVGA      = 11'd1;
	localparam count_t VSYNCPW_SVGA      = 11'd4;
	localparam count_t VBKPRCH_SVGA      = 11'd23;
	localparam logic   NEG_POLARITY_SVGA = 1'b0;

	// 1024x768@60
	localparam count_t HPIXELS_XGA      = 11'd1024;
	localparam count_t HFNPRCH_XGA      = 11'd24;
	localparam count_t HSYNCPW_XGA      = 11'd136;
	localparam count_t HBKPRCH_XGA      = 11'd160;
	localparam count_t VLINES_XGA       = 11'd768;
	localparam count_t VFNPRCH_XGA      = 11'd3;
	localparam count_t VSYNCPW_XGA      = 11'd6;
	localparam count_t VBKPRCH_XGA      = 11'd29;
	localparam logic   NEG_POLARITY_XGA = 1'b1; // Syncs idle high

	// 1280x720@60 power-on default
	localparam count_t HPIXELS_HDTV720P      = 11'd1280;
	localparam count_t HFNPRCH_HDTV720P      = 11'd110;
	localparam count_t HSYNCPW_HDTV720P      = 11'd40;
	localparam count_t HBKPRCH_HDTV720P      = 11'd220;
	localparam count_t VLINES_HDTV720P       = 11'd720;
	localparam count_t VFNPRCH_HDTV720P      = 11'd5;
	localparam count_t VSYNCPW_HDTV720P      = 11'd5;
	localparam count_t VBKPRCH_HDTV720P      = 11'd20;
	localparam logic   NEG_POLARITY_HDTV720P = 1'b0;

	// 1280x1024@60
	localparam count_t HPIXELS_SXGA      = 11'd1280;
	localparam count_t HFNPRCH_SXGA      = 11'd48;
	localparam count_t HSYNCPW_SXGA      = 11'd112;
	localparam count_t HBKPRCH_SXGA      = 11'd248;
	localparam count_t VLINES_SXGA       = 11'd1024;
	localparam count_t VFNPRCH_SXGA      = 11'd1;
	localparam count_t VSYNCPW_SXGA      = 11'd3;
	localparam count_t VBKPRCH_SXGA      = 11'd38;
	localparam logic   NEG_POLARITY_SXGA = 1'b0;

	// Camera 1280x720 with trimmed sync widths
	localparam count_t HPIXELS_CAMERA      = 11'd1280;
	localparam count_t HFNPRCH_CAMERA      = 11'd110;
	localparam count_t HSYNCPW_CAMERA      = 11'd39;
	localparam count_t HBKPRCH_CAMERA      = 11'd220;
	localparam count_t VLINES_CAMERA       = 11'd720;
	localparam count_t VFNPRCH_CAMERA      = 11'd4;
	localparam count_t VSYNCPW_CAMERA      = 11'd4;
	localparam count_t VBKPRCH_CAMERA      = 11'd22;
	localparam logic   NEG_POLARITY_CAMERA = 1'b0;

endpackage

`default_nettype wire

/* timing_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface timing_if
	import video_timing_pkg::*;
();

	count_t hsblnk;       // Last live pixel
	count_t hssync;       // Hsync goes active after this count
	count_t hesync;       // Last hsync count
	count_t heblnk;       // Last count of the line
	count_t vsblnk;       // Last live line
	count_t vssync;
	count_t vesync;
	count_t veblnk;       // Last line of the frame
	logic   neg_polarity; // 1 = syncs idle high
	logic   restart;      // One-cycle pulse on a format change

	modport src (
		output hsblnk, hssync, hesync, heblnk,
		output vsblnk, vssync, vesync, veblnk,
		output neg_polarity, restart
	);

	modport cnt (
		input hsblnk, hssync, hesync, heblnk,
		input vsblnk, vssync, vesync, veblnk,
		input restart
	);

	modport out (input neg_polarity, restart);

endinterface

`default_nettype wire

/* mode_select.sv */
`timescale 1ns/100ps
`default_nettype none

module mode_select
	import video_timing_pkg::*;
(
	input  logic     clk50m_bufg,
	input  logic     RSTBTN,
	input  sw_code_t sw,
	timing_if.src    tif
);

	sw_code_t sw_sync [SW_SYNC_STAGES]; // Switch synchronizer chain
	sw_code_t cur_code;                 // Format currently running
	sw_code_t sel_code;                 // Code fed to the lookup
	logic     change;
	count_t   t_hpix;
	count_t   t_hfp;
	count_t   t_hsw;
	count_t   t_hbp;
	count_t   t_vlin;
	count_t   t_vfp;
	count_t   t_vsw;
	count_t   t_vbp;
	logic     t_neg;

	// Two flop synchronizer without debounce
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			for (int i = 0; i < SW_SYNC_STAGES; i++)
				sw_sync[i] <= SW_HDTV720P;
		end else begin
			sw_sync[0] <= sw;
			for (int i = 1; i < SW_SYNC_STAGES; i++)
				sw_sync[i] <= sw_sync[i-1];
		end
	end

	assign change   = (sw_sync[SW_SYNC_STAGES-1] != cur_code); // Any new code restarts
	assign sel_code = RSTBTN ? SW_HDTV720P : sw_sync[SW_SYNC_STAGES-1];

	////////////////////////////////////////////////////////////////////////////
	// Format table
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		case (sel_code)
			SW_VGA: begin
				t_neg = NEG_POLARITY_VGA;
				{t_hpix, t_hfp, t_hsw, t_hbp} = {HPIXELS_VGA, HFNPRCH_VGA, HSYNCPW_VGA, HBKPRCH_VGA};
				{t_vlin, t_vfp, t_vsw, t_vbp} = {VLINES_VGA, VFNPRCH_VGA, VSYNCPW_VGA, VBKPRCH_VGA};
			end
			SW_SVGA: begin
				t_neg = NEG_POLARITY_SVGA;
				{t_hpix, t_hfp, t_hsw, t_hbp} =
					{HPIXELS_SVGA, HFNPRCH_SVGA, HSYNCPW_SVGA, HBKPRCH_SVGA};
				{t_vlin, t_vfp, t_vsw, t_vbp} =
					{VLINES_SVGA, VFNPRCH_SVGA, VSYNCPW_SVGA, VBKPRCH_SVGA};
			end
			SW_XGA: begin
				t_neg = NEG_POLARITY_XGA;
				{t_hpix, t_hfp, t_hsw, t_hbp} = {HPIXELS_XGA, HFNPRCH_XGA, HSYNCPW_XGA, HBKPRCH_XGA};
				{t_vlin, t_vfp, t_vsw, t_vbp} = {VLINES_XGA, VFNPRCH_XGA, VSYNCPW_XGA, VBKPRCH_XGA};
			end
			SW_SXGA: begin
				t_neg = NEG_POLARITY_SXGA;
				{t_hpix, t_hfp, t_hsw, t_hbp} =
					{HPIXELS_SXGA, HFNPRCH_SXGA, HSYNCPW_SXGA, HBKPRCH_SXGA};
				{t_vlin, t_vfp, t_vsw, t_vbp} =
					{VLINES_SXGA, VFNPRCH_SXGA, VSYNCPW_SXGA, VBKPRCH_SXGA};
			end
			SW_CAMERA: begin
				t_neg = NEG_POLARITY_CAMERA;
				{t_hpix, t_hfp, t_hsw, t_hbp} =
					{HPIXELS_CAMERA, HFNPRCH_CAMERA, HSYNCPW_CAMERA, HBKPRCH_CAMERA};
				{t_vlin, t_vfp, t_vsw, t_vbp} =
					{VLINES_CAMERA, VFNPRCH_CAMERA, VSYNCPW_CAMERA, VBKPRCH_CAMERA};
			end
			default: begin // 720p for SW_HDTV720P or any unlisted code
				t_neg = NEG_POLARITY_HDTV720P;
				{t_hpix, t_hfp, t_hsw, t_hbp} =
					{HPIXELS_HDTV720P, HFNPRCH_HDTV720P, HSYNCPW_HDTV720P, HBKPRCH_HDTV720P};
				{t_vlin, t_vfp, t_vsw, t_vbp} =
					{VLINES_HDTV720P, VFNPRCH_HDTV720P, VSYNCPW_HDTV720P, VBKPRCH_HDTV720P};
			end
		endcase
	end

	// Code and restart pulse
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			cur_code    <= SW_HDTV720P;
			tif.restart <= 1'b0;
		end else begin
			cur_code    <= sw_sync[SW_SYNC_STAGES-1];
			tif.restart <= change; // Same edge as the new thresholds
		end
	end

	// Thresholds only move on reset or a format change
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || change) begin
			tif.hsblnk       <= t_hpix - 11'd1;
			tif.hssync       <= t_hpix - 11'd1 + t_hfp;
			tif.hesync       <= t_hpix - 11'd1 + t_hfp + t_hsw;
			tif.heblnk       <= t_hpix - 11'd1 + t_hfp + t_hsw + t_hbp;
			tif.vsblnk       <= t_vlin - 11'd1;
			tif.vssync       <= t_vlin - 11'd1 + t_vfp;
			tif.vesync       <= t_vlin - 11'd1 + t_vfp + t_vsw;
			tif.veblnk       <= t_vlin - 11'd1 + t_vfp + t_vsw + t_vbp;
			tif.neg_polarity <= t_neg;
		end
	end

endmodule

`default_nettype wire

/* timing_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module timing_counter
	import video_timing_pkg::*;
(
	input  logic   clk50m_bufg,
	input  logic   RSTBTN,
	timing_if.cnt  tif,
	output count_t hcount,
	output count_t vcount,
	output logic   hblnk,
	output logic   vblnk,
	output logic   hsync_act,
	output logic   vsync_act
);

	count_t h_next; // Count value for the coming cycle
	count_t v_next;
	logic   h_wrap; // Last pixel of the line
	logic   v_wrap; // Last line of the frame

	////////////////////////////////////////////////////////////////////////////
	// Next-count logic
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		h_wrap = (hcount >= tif.heblnk);
		v_wrap = (vcount >= tif.veblnk);
		h_next = h_wrap ? '0 : hcount + 11'd1;
		v_next = vcount;
		if (h_wrap) begin
			v_next = v_wrap ? '0 : vcount + 11'd1; // Line advances on pixel wrap
		end
		if (tif.restart) begin
			// New format starts at the top left
			h_next = '0;
			v_next = '0;
		end
	end

	// Flags come from the next count so they line up with it
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hcount    <= '0;
			vcount    <= '0;
			hblnk     <= 1'b0;
			vblnk     <= 1'b0;
			hsync_act <= 1'b0;
			vsync_act <= 1'b0;
		end else begin
			hcount    <= h_next;
			vcount    <= v_next;
			hblnk     <= (h_next > tif.hsblnk);  // Past last live pixel
			hsync_act <= (h_next > tif.hssync) && (h_next <= tif.hesync);
			vblnk     <= (v_next > tif.vsblnk);  // Past last live line
			vsync_act <= (v_next > tif.vssync) && (v_next <= tif.vesync);
		end
	end

endmodule

`default_nettype wire

/* sync_output.sv */
`timescale 1ns/100ps
`default_nettype none

module sync_output
	import video_timing_pkg::*;
(
	input  logic   clk50m_bufg,
	input  logic   RSTBTN,
	timing_if.out  tif,
	input  count_t hcount_in,
	input  count_t vcount_in,
	input  logic   hblnk,
	input  logic   vblnk,
	input  logic   hsync_act,
	input  logic   vsync_act,
	output logic   hsync,
	output logic   vsync,
	output logic   de,
	output count_t hcount,
	output count_t vcount
);

	logic   hsync_q; // Stage 1
	logic   vsync_q;
	logic   de_q;
	count_t hcount_q;
	count_t vcount_q;

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			// 720p idle levels
			hsync_q  <= NEG_POLARITY_HDTV720P;
			vsync_q  <= NEG_POLARITY_HDTV720P;
			de_q     <= 1'b0;
			hcount_q <= '0;
			vcount_q <= '0;
			hsync    <= NEG_POLARITY_HDTV720P;
			vsync    <= NEG_POLARITY_HDTV720P;
			de       <= 1'b0;
			hcount   <= '0;
			vcount   <= '0;
		end else begin
			if (tif.restart) begin
				// Load the cleared state a cycle ahead of the counter
				hsync_q  <= tif.neg_polarity;
				vsync_q  <= tif.neg_polarity;
				de_q     <= 1'b0;
				hcount_q <= '0;
				vcount_q <= '0;
			end else begin
				hsync_q  <= hsync_act ^ tif.neg_polarity; // Polarity applied here
				vsync_q  <= vsync_act ^ tif.neg_polarity;
				de_q     <= !hblnk && !vblnk;
				hcount_q <= hcount_in;
				vcount_q <= vcount_in;
			end
			// Stage 2
			hsync  <= hsync_q;
			vsync  <= vsync_q;
			de     <= de_q && !tif.restart; // No partial line shows as live
			hcount <= hcount_q;
			vcount <= vcount_q;
		end
	end

endmodule

`default_nettype wire

/* video_timing_top.sv */
`timescale 1ns/100ps
`default_nettype none

module video_timing_top
	import video_timing_pkg::*;
(
	input  logic     clk50m_bufg,
	input  logic     RSTBTN,
	input  sw_code_t sw,    // Format select switches
	output logic     hsync,
	output logic     vsync,
	output logic     de,
	output count_t   hcount,
	output count_t   vcount
);

	timing_if tif (); // Thresholds, polarity, restart

	count_t cnt_hcount; // Raw counter state
	count_t cnt_vcount;
	logic   cnt_hblnk;
	logic   cnt_vblnk;
	logic   cnt_hsync_act;
	logic   cnt_vsync_act;

	////////////////////////////////////////////////////////////////////////////
	// Format select, counting, output alignment
	////////////////////////////////////////////////////////////////////////////
	mode_select u_mode_select (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.tif         (tif.src)
	);

	timing_counter u_timing_counter (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.tif         (tif.cnt),
		.hcount      (cnt_hcount),
		.vcount      (cnt_vcount),
		.hblnk       (cnt_hblnk),
		.vblnk       (cnt_vblnk),
		.hsync_act   (cnt_hsync_act),
		.vsync_act   (cnt_vsync_act)
	);

	sync_output u_sync_output (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.tif         (tif.out),
		.hcount_in   (cnt_hcount),
		.vcount_in   (cnt_vcount),
		.hblnk       (cnt_hblnk),
		.vblnk       (cnt_vblnk),
		.hsync_act   (cnt_hsync_act),
		.vsync_act   (cnt_vsync_act),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.hcount      (hcount),
		.vcount      (vcount)
	);

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic clk50m_bufg,
	output logic RSTBTN
);

	localparam int HALF_PERIOD  = 10; // 20 ns clock
	localparam int RESET_CYCLES = 10;

	initial begin
		clk50m_bufg = 1'b0;
		forever #(HALF_PERIOD) clk50m_bufg = ~clk50m_bufg;
	end

	// Reset released on a rising edge
	initial begin
		RSTBTN = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk50m_bufg);
		RSTBTN <= 1'b0;
	end

endmodule

`default_nettype wire

/* video_timing_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module video_timing_properties
	import video_timing_pkg::*;
(
	input logic   clk50m_bufg,
	input logic   RSTBTN,
	input logic   de,
	input count_t hcount,
	input count_t vcount,
	input count_t hsblnk  // Last live pixel of the running format
);

	int n_fail = 0; // Assertion failures so far

	// Live pixels only start inside the active width
	de_rise_in_line: assert property (
		@(posedge clk50m_bufg) disable iff (RSTBTN)
		$rose(de) |-> (hcount <= hsblnk)
	) else begin
		n_fail++;
		$error("de rose at hcount %h, last live pixel %h", hcount, hsblnk);
	end

	// Pixel count steps by one or wraps
	hcount_step: assert property (
		@(posedge clk50m_bufg) disable iff (RSTBTN)
		(hcount == $past(hcount) + 11'd1) || (hcount == '0)
	) else begin
		n_fail++;
		$error("hcount jumped from %h to %h", $past(hcount), hcount);
	end

	// Line count only moves at the start of a line
	vcount_on_wrap: assert property (
		@(posedge clk50m_bufg) disable iff (RSTBTN)
		(vcount != $past(vcount)) |-> (hcount == '0)
	) else begin
		n_fail++;
		$error("vcount changed to %h at hcount %h", vcount, hcount);
	end

endmodule

bind video_timing_top video_timing_properties u_properties (
	.clk50m_bufg (clk50m_bufg),
	.RSTBTN      (RSTBTN),
	.de          (de),
	.hcount      (hcount),
	.vcount      (vcount),
	.hsblnk      (tif.hsblnk)
);

`default_nettype wire

/* video_timing_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module video_timing_tb
	import video_timing_pkg::*;
();

	localparam int          NUM_PAT        = 7;  // Lines in the pattern file
	localparam int          PAT_COLS       = 9;
	localparam int          LINES_PER_TEST = 2;  // Horizontal lines measured per format
	localparam int          CHANGE_CYCLES  = 16; // Restart path plus slack
	localparam logic [31:0] SEED           = 32'ha31acd12;

	logic        clk50m_bufg;
	logic        RSTBTN;
	sw_code_t    sw;
	logic        hsync;
	logic        vsync;
	logic        de;
	count_t      hcount;
	count_t      vcount;
	logic [15:0] pat_mem [NUM_PAT*PAT_COLS]; // PAT_COLS words per pattern line
	int          order [NUM_PAT];            // Shuffled test order
	int          n_checks    = 0;
	int          n_errors    = 0;
	int          n_tests     = 0;
	int          cycles      = 0;
	int          cycle_limit = 0;

	tb_clock_gen u_clk (.clk50m_bufg(clk50m_bufg), .RSTBTN(RSTBTN));

	video_timing_top u_dut (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.hcount      (hcount),
		.vcount      (vcount)
	);

	////////////////////////////////////////////////////////////////////////////
	// Compare helpers
	////////////////////////////////////////////////////////////////////////////
	function automatic int pat_word(input int p, input int c);
		return int'(pat_mem[p*PAT_COLS + c]);
	endfunction

	task automatic check_count(input string name, input count_t got, input count_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_code(input string name, input sw_code_t got, input sw_code_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic end_test(input string name, input int start_err);
		n_tests++;
		$display("test %0d %s: %0d errors", n_tests, name, n_errors - start_err);
	endtask

	// Outputs idle at the 720p level right after reset
	task automatic check_reset();
		int start_err;
		start_err = n_errors;
		@(negedge RSTBTN);
		repeat (OUT_LATENCY) begin
			@(negedge clk50m_bufg); // Mid-cycle with outputs settled
			check_level("de", de, 1'b0);
			check_count("hcount", hcount, '0);
			check_count("vcount", vcount, '0);
			check_level("hsync", hsync, NEG_POLARITY_HDTV720P);
			check_level("vsync", vsync, NEG_POLARITY_HDTV720P);
		end
		end_test("reset", start_err);
	endtask

	// Drive a new code and follow the restart to the ports
	task automatic apply_format(input int p);
		sw_code_t code;
		code = sw_code_t'(pat_word(p, 0));
		@(posedge clk50m_bufg);
		if (code != sw) begin
			sw <= code;
			repeat (SW_SYNC_STAGES + 1 + OUT_LATENCY) @(negedge clk50m_bufg); // Cycle 4
			check_level("de before restart zero", de, 1'b0);
			@(negedge clk50m_bufg); // 5 cycles after the switch edge
			check_count("hcount after change", hcount, '0);
			check_count("vcount after change", vcount, '0);
			check_level("de after change", de, 1'b0);
			@(negedge clk50m_bufg); // First live pixel of the new format
			check_level("de first pixel", de, 1'b1);
			check_count("hcount first pixel", hcount, '0);
			@(negedge clk50m_bufg);
			check_count("hcount second pixel", hcount, 11'd1);
		end
		check_code("cur_code", u_dut.u_mode_select.cur_code, code);
	endtask

	// One line from de rise to the next hsync active edge
	task automatic measure_line(input int p);
		logic pol;
		logic prev_de;
		int   t;
		int   de_len;
		int   hs_start;
		int   hs_len;
		pol     = (pat_word(p, 8) != 0);
		prev_de = de;
		@(negedge clk50m_bufg);
		while (!(de && !prev_de)) begin
			prev_de = de;
			@(negedge clk50m_bufg);
		end
		check_level("hsync idle", hsync, pol); // Both syncs idle in live video
		check_level("vsync idle", vsync, pol);
		check_count("hcount at de rise", hcount, '0);
		t = 0;
		while (de) begin
			@(negedge clk50m_bufg);
			t++;
		end
		de_len = t;
		while (!(hsync ^ pol)) begin // Front porch
			@(negedge clk50m_bufg);
			t++;
		end
		hs_start = t;
		while (hsync ^ pol) begin
			@(negedge clk50m_bufg);
			t++;
		end
		hs_len = t - hs_start;
		while (!(hsync ^ pol)) begin // Back porch into next line
			@(negedge clk50m_bufg);
			t++;
		end
		check_count("de width", count_t'(de_len), count_t'(pat_word(p, 1)));
		check_count("hsync start", count_t'(hs_start), count_t'(pat_word(p, 4)));
		check_count("hsync width", count_t'(hs_len), count_t'(pat_word(p, 3)));
		check_count("hsync period", count_t'(t - hs_start), count_t'(pat_word(p, 2)));
	endtask

	// Lines counted as hsync active edges between two vsync active edges
	task automatic measure_frame(input int p);
		logic pol;
		logic vs_now;
		logic vs_prev;
		logic hs_now;
		logic hs_prev;
		logic de_prev;
		int   frame_lines;
		int   sync_lines;
		int   live_lines;
		pol     = (pat_word(p, 8) != 0);
		vs_prev = vsync ^ pol;
		@(negedge clk50m_bufg);
		while (!((vsync ^ pol) && !vs_prev)) begin
			vs_prev = vsync ^ pol;
			@(negedge clk50m_bufg);
		end
		frame_lines = 0;
		sync_lines  = 0;
		live_lines  = 0;
		vs_prev     = 1'b1;
		hs_prev     = hsync ^ pol;
		de_prev     = de;
		@(negedge clk50m_bufg);
		vs_now = vsync ^ pol;
		hs_now = hsync ^ pol;
		while (!(vs_now && !vs_prev)) begin
			if (hs_now && !hs_prev) begin
				frame_lines++;
				if (vs_now)
					sync_lines++;
			end
			if (de && !de_prev)
				live_lines++;
			vs_prev = vs_now;
			hs_prev = hs_now;
			de_prev = de;
			@(negedge clk50m_bufg);
			vs_now = vsync ^ pol;
			hs_now = hsync ^ pol;
		end
		check_count("vsync period lines", count_t'(frame_lines), count_t'(pat_word(p, 6)));
		check_count("vsync width lines", count_t'(sync_lines), count_t'(pat_word(p, 7)));
		check_count("live lines", count_t'(live_lines), count_t'(pat_word(p, 5)));
	endtask

	task automatic run_pattern(input int p);
		int start_err;
		start_err = n_errors;
		apply_format(p);
		for (int i = 0; i < LINES_PER_TEST; i++)
			measure_line(p);
		if (sw_code_t'(pat_word(p, 0)) == SW_VGA)
			measure_frame(p); // Vertical timing on VGA only
		end_test($sformatf("sw %h htotal %0d", pat_word(p, 0), pat_word(p, 2)), start_err);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Watchdog
	////////////////////////////////////////////////////////////////////////////
	always @(posedge clk50m_bufg) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, expected sync edges never came", cycles);
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		int   j;
		int   tmp;
		int   vga_frame;
		logic loaded;
		sw = SW_HDTV720P; // Reset default so no restart
		$readmemh("video_timing_patterns.txt", pat_mem);
		loaded = 1'b1;
		for (int i = 0; i < NUM_PAT*PAT_COLS; i++)
			if ($isunknown(pat_mem[i]))
				loaded = 1'b0;
		// Limit from the tests' own lengths
		vga_frame = 0;
		for (int p = 0; p < NUM_PAT; p++) begin
			cycle_limit += (2*LINES_PER_TEST + 1) * pat_word(p, 2) + CHANGE_CYCLES;
			if (sw_code_t'(pat_word(p, 0)) == SW_VGA)
				vga_frame = pat_word(p, 6) * pat_word(p, 2);
		end
		cycle_limit += vga_frame;        // Frame measured in the VGA test
		cycle_limit += vga_frame + 1000; // Margin for the first vsync edge and reset
		void'($urandom(SEED));
		for (int i = 0; i < NUM_PAT; i++)
			order[i] = i;
		for (int i = NUM_PAT - 1; i > 0; i--) begin // Shuffle
			j        = $urandom % (i + 1);
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		check_reset();
		if (loaded) begin
			for (int i = 0; i < NUM_PAT; i++)
				run_pattern(order[i]);
		end else begin
			n_errors++;
			$display("Pattern file could not be read in full, no format tests run");
		end
		if (u_dut.u_properties.n_fail != 0) begin
			n_errors += u_dut.u_properties.n_fail;
			$display("%0d port timing assertions failed", u_dut.u_properties.n_fail);
		end
		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* video_timing_patterns.txt */
// sw hpixels htotal hsyncpw hsync_start vlines vtotal vsyncpw neg_polarity
// All hex, hsync_start counted from the first live pixel
0 280 320 60 290 1E0 20C 2 1
1 320 420 80 348 258 274 4 0
2 500 672 28 56E 2D0 2EE 5 0
3 400 540 88 418 300 326 6 1
8 500 698 70 530 400 42A 3 0
9 500 671 27 56E 2D0 2EE 4 0
7 500 672 28 56E 2D0 2EE 5 0

/* video_timing_top.f */
video_timing_pkg.sv
timing_if.sv
mode_select.sv
timing_counter.sv
sync_output.sv
video_timing_top.sv
tb_clock_gen.sv
video_timing_properties.sv
video_timing_tb.sv
